// File: design/dtim_pkg.sv
package dtim_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // CPU side
  // ~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic        valid;
    logic        fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // Zero for a read
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } cpu_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Memory side
  // ~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } mem_rsp_t;

  typedef struct packed {
    logic        present;
    logic        dirty;
    logic [29:0] addr;   // Full word address
    logic [31:0] data;
  } line_t;

  typedef enum logic [1:0] {
    st_lookup,
    st_fill,
    st_bypass,
    st_flush
  } dtim_state_e;

endpackage

// File: design/dtim_ram.sv
`timescale 1ns/1ns

module dtim_ram #(
  parameter int lines = 256
) (
  input  logic                     clock,
  input  logic [$clog2(lines)-1:0] raddr,
  input  logic [$clog2(lines)-1:0] waddr,
  input  logic                     wen,
  input  dtim_pkg::line_t          wdata,
  output dtim_pkg::line_t          rdata
);

  import dtim_pkg::*;

  line_t                    store [lines] = '{default: '0};
  logic [$clog2(lines)-1:0] raddr_q = '0;

  always_ff @(posedge clock) begin
    raddr_q <= raddr;
    if (wen) begin
      store[waddr] <= wdata;
    end
  end

  assign rdata = store[raddr_q];  // One cycle after raddr

endmodule

// File: design/dtim_req_stage.sv
`timescale 1ns/1ns

module dtim_req_stage #(
  parameter int          lines     = 256,
  parameter logic [31:0] base_addr = 32'h1000_0000,
  parameter logic [31:0] top_addr  = 32'h1001_0000
) (
  input  logic                     clock,
  input  logic                     reset,
  input  dtim_pkg::cpu_req_t       cpu_req,
  output dtim_pkg::cpu_req_t       req,
  output logic [$clog2(lines)-1:0] index,
  output logic [$clog2(lines)-1:0] lookup_index,
  output logic                     in_range
);

  localparam int idx_w = $clog2(lines);

  always_ff @(posedge clock) begin
    if (!reset) begin
      req.valid <= 1'b0;
      req.fence <= 1'b0;
    end else begin
      req.valid <= cpu_req.valid;  // One-cycle pulse, a cycle late
      if (cpu_req.valid) begin
        req.fence <= cpu_req.fence;
        req.addr  <= {cpu_req.addr[31:2], 2'b00};  // Word aligned
        req.wdata <= cpu_req.wdata;
        req.wstrb <= cpu_req.wstrb;
      end
    end
  end

  // RAM read starts in the valid cycle
  assign lookup_index = cpu_req.addr[idx_w+1:2];

  assign index    = req.addr[idx_w+1:2];
  assign in_range = (req.addr >= base_addr) && (req.addr < top_addr);

endmodule

// File: design/dtim_flush.sv
`timescale 1ns/1ns

module dtim_flush #(
  parameter int lines = 256
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  dtim_pkg::line_t          line,
  input  logic                     mem_ready,
  output logic [$clog2(lines)-1:0] scan_index,
  output logic                     clear,
  output dtim_pkg::mem_req_t       wb_req,
  output logic                     done
);

  logic busy;
  logic primed;   // Line input holds the data of scan_index
  logic pending;  // Write-back in flight
  logic dirty;
  logic advance;
  logic last;

  assign dirty   = line.present && line.dirty;
  assign advance = busy && primed && (pending ? mem_ready : !dirty);
  assign last    = &scan_index;

  // Full-strobe write-back of the scanned line
  assign wb_req.valid = busy && primed && dirty && !pending;
  assign wb_req.addr  = {line.addr, 2'b00};
  assign wb_req.wdata = line.data;
  assign wb_req.wstrb = 4'hf;

  assign clear = advance;
  assign done  = advance && last;

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy       <= 1'b0;
      primed     <= 1'b0;
      pending    <= 1'b0;
      scan_index <= '0;
    end else if (start) begin
      busy       <= 1'b1;
      primed     <= 1'b0;
      pending    <= 1'b0;
      scan_index <= '0;
    end else if (busy) begin
      primed <= 1'b1;  // First read lands one cycle in
      if (wb_req.valid) begin
        pending <= 1'b1;
      end
      if (advance) begin
        pending <= 1'b0;
        if (last) begin
          busy   <= 1'b0;
          primed <= 1'b0;
        end else begin
          scan_index <= scan_index + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/dtim_ctrl.sv
`timescale 1ns/1ns

module dtim_ctrl #(
  parameter int lines = 256
) (
  input  logic                     clock,
  input  logic                     reset,
  input  dtim_pkg::cpu_req_t       req,
  input  logic [$clog2(lines)-1:0] index,
  input  logic [$clog2(lines)-1:0] lookup_index,
  input  logic                     in_range,
  input  logic                     cpu_valid,
  input  dtim_pkg::line_t          line,
  output logic [$clog2(lines)-1:0] ram_raddr,
  output logic [$clog2(lines)-1:0] ram_waddr,
  output logic                     ram_wen,
  output dtim_pkg::line_t          ram_wdata,
  input  logic [$clog2(lines)-1:0] scan_index,
  input  logic                     flush_clear,
  input  dtim_pkg::mem_req_t       flush_req,
  input  logic                     flush_done,
  output logic                     flush_start,
  input  dtim_pkg::mem_rsp_t       mem_rsp,
  output dtim_pkg::mem_req_t       mem_req,
  output dtim_pkg::cpu_rsp_t       cpu_rsp
);

  import dtim_pkg::*;

  dtim_state_e state;
  dtim_state_e state_next;
  logic        is_write;
  logic        addr_match;

  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strb
  );
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  assign is_write   = |req.wstrb;
  assign addr_match = line.addr == req.addr[31:2];

  // ~~~~~~~~~~~~~~~~~~~~
  // RAM read address
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (state == st_flush) begin
      ram_raddr = flush_clear ? scan_index + 1'b1 : scan_index;  // Read ahead on advance
    end else if (cpu_valid) begin
      ram_raddr = lookup_index;
    end else begin
      ram_raddr = index;  // Hold the line of the open request
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Request FSM
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next  = state;
    flush_start = 1'b0;
    cpu_rsp     = '0;
    mem_req     = '0;
    ram_wen     = 1'b0;
    ram_waddr   = index;
    ram_wdata   = '0;
    case (state)
      st_lookup: begin
        if (req.valid) begin
          if (req.fence) begin
            flush_start = 1'b1;
            state_next  = st_flush;
          end else if (!in_range || (line.present && !addr_match)) begin
            mem_req.valid = 1'b1;  // Straight to memory
            mem_req.addr  = req.addr;
            mem_req.wdata = req.wdata;
            mem_req.wstrb = req.wstrb;
            state_next    = st_bypass;
          end else if (!line.present) begin
            mem_req.valid = 1'b1;  // Fill read
            mem_req.addr  = req.addr;
            state_next    = st_fill;
          end else begin
            cpu_rsp.ready     = 1'b1;
            cpu_rsp.rdata     = line.data;
            ram_wen           = is_write;
            ram_wdata.present = 1'b1;
            ram_wdata.dirty   = 1'b1;
            ram_wdata.addr    = req.addr[31:2];
            ram_wdata.data    = merge_bytes(line.data, req.wdata, req.wstrb);
          end
        end
      end
      st_fill: begin
        if (mem_rsp.ready) begin
          cpu_rsp.ready     = 1'b1;
          cpu_rsp.rdata     = mem_rsp.rdata;
          ram_wen           = 1'b1;
          ram_wdata.present = 1'b1;
          ram_wdata.dirty   = is_write;
          ram_wdata.addr    = req.addr[31:2];
          ram_wdata.data    = merge_bytes(mem_rsp.rdata, req.wdata, req.wstrb);
          state_next        = st_lookup;
        end
      end
      st_bypass: begin
        if (mem_rsp.ready) begin
          cpu_rsp.ready = 1'b1;
          cpu_rsp.rdata = mem_rsp.rdata;
          state_next    = st_lookup;
        end
      end
      st_flush: begin
        mem_req   = flush_req;
        ram_wen   = flush_clear;
        ram_waddr = scan_index;  // Zero line on clear
        if (flush_done) begin
          cpu_rsp.ready = 1'b1;  // Fence answers with zero data
          state_next    = st_lookup;
        end
      end
      default: begin
        state_next = st_lookup;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_lookup;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: design/dtim.sv
`timescale 1ns/1ns

module dtim #(
  parameter int          lines     = 256,
  parameter logic [31:0] base_addr = 32'h1000_0000,
  parameter logic [31:0] top_addr  = 32'h1001_0000
) (
  input  logic               clock,
  input  logic               reset,
  input  dtim_pkg::cpu_req_t cpu_req,
  output dtim_pkg::cpu_rsp_t cpu_rsp,
  output dtim_pkg::mem_req_t mem_req,
  input  dtim_pkg::mem_rsp_t mem_rsp
);

  import dtim_pkg::*;

  cpu_req_t                 req;
  logic [$clog2(lines)-1:0] index;
  logic [$clog2(lines)-1:0] lookup_index;
  logic                     in_range;
  line_t                    line;
  logic [$clog2(lines)-1:0] ram_raddr;
  logic [$clog2(lines)-1:0] ram_waddr;
  logic                     ram_wen;
  line_t                    ram_wdata;
  logic [$clog2(lines)-1:0] scan_index;
  logic                     flush_clear;
  mem_req_t                 flush_req;
  logic                     flush_done;
  logic                     flush_start;

  dtim_req_stage #(
    .lines     (lines),
    .base_addr (base_addr),
    .top_addr  (top_addr)
  ) i_req_stage (
    .*
  );

  dtim_ctrl #(
    .lines (lines)
  ) i_ctrl (
    .cpu_valid (cpu_req.valid),
    .*
  );

  dtim_flush #(
    .lines (lines)
  ) i_flush (
    .clock      (clock),
    .reset      (reset),
    .start      (flush_start),
    .line       (line),
    .mem_ready  (mem_rsp.ready),
    .scan_index (scan_index),
    .clear      (flush_clear),
    .wb_req     (flush_req),
    .done       (flush_done)
  );

  dtim_ram #(
    .lines (lines)
  ) i_ram (
    .clock (clock),
    .raddr (ram_raddr),
    .waddr (ram_waddr),
    .wen   (ram_wen),
    .wdata (ram_wdata),
    .rdata (line)
  );

endmodule

// File: tb/dtim_tb_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~
// Model access and checks
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic [31:0] mem_peek(input logic [31:0] addr);
  if (!mem_words.exists(addr[31:2])) begin
    mem_words[addr[31:2]] = $random(seed);  // First touch sets the initial word
  end
  return mem_words[addr[31:2]];
endfunction

function automatic cpu_rsp_t ready_rsp(input logic [31:0] data);
  cpu_rsp_t rsp;
  rsp.rdata = data;
  rsp.ready = 1'b1;
  return rsp;
endfunction

task automatic check_cpu_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    test_errors++;
    $display("** Error at %0t ns: %s: rdata %h ready %b, expected rdata %h ready %b",
             $time, what, got.rdata, got.ready, exp.rdata, exp.ready);
  end
endtask

task automatic check_mem_word(input logic [31:0] addr, input logic [31:0] exp_word,
                              input int exp_writes);
  logic [31:0] word;
  word = mem_peek(addr);
  checks++;
  if (word !== exp_word || write_count != exp_writes) begin
    errors++;
    test_errors++;
    $display("** Error at %0t ns: memory %h holds %h after %0d writes, expected %h after %0d",
             $time, addr, word, write_count, exp_word, exp_writes);
  end
endtask

task automatic check_count(input int got, input int exp, input string what);
  checks++;
  if (got != exp) begin
    errors++;
    test_errors++;
    $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic report_test(input string name);
  tests++;
  if (test_errors == 0) begin
    $display("test %s: ok", name);
  end else begin
    $display("test %s: %0d errors", name, test_errors);
  end
  test_errors = 0;
endtask

// ~~~~~~~~~~~~~~~~~~~~
// CPU requests
// ~~~~~~~~~~~~~~~~~~~~

task automatic issue_request(input logic fence, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             output cpu_rsp_t rsp, output int cycles);
  @(posedge clock);
  #1;
  cpu_req.valid = 1'b1;
  cpu_req.fence = fence;
  cpu_req.addr  = addr;
  cpu_req.wdata = wdata;
  cpu_req.wstrb = wstrb;
  @(posedge clock);
  #1;
  cpu_req = '0;  // One-cycle valid
  cycles  = 1;
  @(negedge clock);
  while (cpu_rsp.ready !== 1'b1) begin
    @(negedge clock);
    cycles++;
  end
  rsp = cpu_rsp;
endtask

task automatic cpu_read(input logic [31:0] addr, output cpu_rsp_t rsp, output int cycles);
  issue_request(1'b0, addr, 32'h0, 4'h0, rsp, cycles);
endtask

task automatic cpu_write(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, output cpu_rsp_t rsp, output int cycles);
  issue_request(1'b0, addr, wdata, wstrb, rsp, cycles);
endtask

// ~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~

task automatic read_miss_then_hit();
  cpu_rsp_t    rsp;
  int          cycles;
  int          reqs;
  logic [31:0] word;
  word = mem_peek(addr_a);
  cpu_read(addr_a, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(word), "read miss");
  reqs = req_count;
  cpu_read(addr_a, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(word), "read hit");
  check_count(cycles, 1, "read hit latency");
  @(negedge clock);  // A request in the hit cycle reaches the model by now
  check_count(req_count, reqs, "memory requests on read hit");
  report_test("read miss then hit");
endtask

task automatic write_hit_merge();
  cpu_rsp_t    rsp;
  int          cycles;
  int          writes;
  logic [31:0] old;
  old    = mem_peek(addr_a);
  writes = write_count;
  cpu_write(addr_a, 32'haabb_ccdd, 4'b0101, rsp, cycles);
  check_count(cycles, 1, "write hit latency");
  merged_a = {old[31:24], 8'hbb, old[15:8], 8'hdd};  // Bytes 0 and 2 replaced
  cpu_read(addr_a, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(merged_a), "read after write hit");
  check_mem_word(addr_a, old, writes);
  report_test("write hit merge");
endtask

task automatic write_miss_fill();
  cpu_rsp_t    rsp;
  int          cycles;
  int          writes;
  logic [31:0] old;
  old    = mem_peek(addr_b);
  writes = write_count;
  cpu_write(addr_b, 32'h1122_3344, 4'b1010, rsp, cycles);
  merged_b = {8'h11, old[23:16], 8'h33, old[7:0]};  // Bytes 1 and 3 replaced
  cpu_read(addr_b, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(merged_b), "read after write miss");
  check_mem_word(addr_b, old, writes);
  report_test("write miss fill");
endtask

task automatic outside_window();
  cpu_rsp_t rsp;
  int       cycles;
  int       writes;
  int       reqs;
  writes = write_count;
  reqs   = req_count;
  cpu_write(addr_c, 32'hcafe_f00d, 4'hf, rsp, cycles);
  check_mem_word(addr_c, 32'hcafe_f00d, writes + 1);
  cpu_read(addr_c, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(32'hcafe_f00d), "read outside window");
  check_count(req_count, reqs + 2, "memory requests outside window");
  report_test("outside window");
endtask

task automatic index_conflict();
  cpu_rsp_t    rsp;
  int          cycles;
  int          reqs;
  logic [31:0] word;
  word = mem_peek(addr_d);
  reqs = req_count;
  cpu_read(addr_d, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(word), "read of conflicting address");
  check_count(req_count, reqs + 1, "memory requests on conflict");
  cpu_read(addr_a, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(merged_a), "reread of resident line");
  check_count(cycles, 1, "resident line latency");
  @(negedge clock);  // A request in the hit cycle reaches the model by now
  check_count(req_count, reqs + 1, "memory requests on resident reread");
  report_test("index conflict");
endtask

task automatic fence_flush();
  cpu_rsp_t rsp;
  int       cycles;
  int       writes;
  int       reqs;
  writes = write_count;
  issue_request(1'b1, 32'h0, 32'h0, 4'h0, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(32'h0), "fence response");
  check_mem_word(addr_a, merged_a, writes + 2);  // Two dirty lines
  check_mem_word(addr_b, merged_b, writes + 2);
  reqs = req_count;
  cpu_read(addr_a, rsp, cycles);
  check_cpu_rsp(rsp, ready_rsp(merged_a), "reread after fence");
  check_count(req_count, reqs + 1, "memory requests on reread after fence");
  report_test("fence flush");
endtask

// File: tb/dtim_tb.sv
`timescale 1ns/1ns

module dtim_tb;

  import dtim_pkg::*;

  localparam int lines      = 16;
  localparam int max_cycles = 2000;  // Six tests and a 16-line fence stay well below

  localparam logic [31:0] addr_a = 32'h1000_0010;  // Index 4
  localparam logic [31:0] addr_b = 32'h1000_0020;  // Index 8
  localparam logic [31:0] addr_c = 32'h2000_0030;  // Outside the window
  localparam logic [31:0] addr_d = 32'h1000_0050;  // Index 4 again

  logic     clock = 1'b0;
  logic     reset;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp = '0;

  // Memory model
  logic [31:0] mem_words [logic [29:0]];
  integer      seed = 37;
  mem_req_t    seen_req;
  mem_req_t    mem_pending;
  int          mem_wait    = 0;
  int          write_count = 0;
  int          req_count   = 0;

  int          cycle_count = 0;
  int          tests       = 0;
  int          checks      = 0;
  int          errors      = 0;
  int          test_errors = 0;
  logic [31:0] merged_a;
  logic [31:0] merged_b;

  dtim #(
    .lines (lines)
  ) i_dtim (
    .clock   (clock),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always #10 clock = ~clock;

  `include "dtim_tb_tasks.svh"

  // ~~~~~~~~~~~~~~~~~~~~
  // Memory model
  // ~~~~~~~~~~~~~~~~~~~~

  always @(negedge clock) begin
    seen_req = mem_req;  // Mid-cycle sample
  end

  always @(posedge clock) begin
    logic [31:0] word;
    #1;
    mem_rsp = '0;
    if (mem_wait > 0) begin
      mem_wait--;
      if (mem_wait == 0) begin
        word = mem_peek(mem_pending.addr);
        if (mem_pending.wstrb != 4'h0) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_pending.wstrb[b]) begin
              word[b*8 +: 8] = mem_pending.wdata[b*8 +: 8];
            end
          end
          mem_words[mem_pending.addr[31:2]] = word;
          write_count++;
        end
        mem_rsp.rdata = word;
        mem_rsp.ready = 1'b1;  // Two cycles after valid
      end
    end
    if (seen_req.valid === 1'b1) begin
      mem_pending = seen_req;
      mem_wait    = 1;
      req_count++;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: no end of tests after %0d cycles", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    reset   = 1'b0;
    cpu_req = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;
    read_miss_then_hit();
    write_hit_merge();
    write_miss_fill();
    outside_window();
    index_conflict();
    fence_flush();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+tb
design/dtim_pkg.sv
design/dtim_ram.sv
design/dtim_req_stage.sv
design/dtim_flush.sv
design/dtim_ctrl.sv
design/dtim.sv
tb/dtim_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = dtim_tb
FILELIST = src.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
